/* rtl/rv_pkg.sv */
package rv_pkg;

    ////////////////////
    // Widths with a meaning
    typedef logic [31:0] word_t;      // Data, instruction or PC
    typedef logic [4:0]  reg_addr_t;  // x0 reads as zero

    localparam int IMEM_ADDR_W = 4;   // 16 instruction words
    localparam int DMEM_ADDR_W = 6;   // 64 data words

    typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;
    typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    ////////////////////
    // Opcodes of the supported subset
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam word_t NOP_INSTR = 32'h0000_0013;  // ADDI x0, x0, 0

endpackage

/* rtl/hazard_unit.sv */
module hazard_unit (
    input  rv_pkg::reg_addr_t rs1_addr_i,
    input  rv_pkg::reg_addr_t rs2_addr_i,
    input  rv_pkg::reg_addr_t id_ex_rd_i,
    input  logic              id_ex_mem_read_i,
    input  rv_pkg::reg_addr_t id_ex_rs1_addr_i,
    input  rv_pkg::reg_addr_t id_ex_rs2_addr_i,
    input  rv_pkg::reg_addr_t ex_mem_rd_i,
    input  logic              ex_mem_reg_write_i,
    input  rv_pkg::reg_addr_t mem_wb_rd_i,
    input  logic              mem_wb_reg_write_i,
    input  logic              branch_taken_i,
    output logic              stall_o,
    output logic              flush_o,
    output rv_pkg::fwd_sel_e  fwd_a_o,
    output rv_pkg::fwd_sel_e  fwd_b_o
);
    import rv_pkg::*;

    // Younger result in MEM beats the older one in WB
    function automatic fwd_sel_e fwd_select(reg_addr_t src, reg_addr_t mem_rd, logic mem_we,
                                            reg_addr_t wb_rd, logic wb_we);
        if (mem_we && mem_rd != '0 && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_we && wb_rd != '0 && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    ////////////////////
    // Load-use stall and branch flush
    assign stall_o = id_ex_mem_read_i && (id_ex_rd_i != '0) &&
                     ((id_ex_rd_i == rs1_addr_i) || (id_ex_rd_i == rs2_addr_i));
    assign flush_o = branch_taken_i;  // Fetch gives the branch priority over a stall

    ////////////////////
    // Operand forwarding into execute
    assign fwd_a_o = fwd_select(id_ex_rs1_addr_i, ex_mem_rd_i, ex_mem_reg_write_i,
                                mem_wb_rd_i, mem_wb_reg_write_i);
    assign fwd_b_o = fwd_select(id_ex_rs2_addr_i, ex_mem_rd_i, ex_mem_reg_write_i,
                                mem_wb_rd_i, mem_wb_reg_write_i);

endmodule

/* rtl/fetch_stage.sv */
module fetch_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               imem_we_i,
    input  rv_pkg::imem_addr_t imem_addr_i,
    input  rv_pkg::word_t      imem_wdata_i,
    input  logic               stall_i,
    input  logic               flush_i,
    input  logic               branch_taken_i,
    input  rv_pkg::word_t      branch_target_i,
    output rv_pkg::word_t      if_id_instr_o,
    output rv_pkg::word_t      if_id_pc_o
);
    import rv_pkg::*;

    word_t pc;
    word_t imem [2**IMEM_ADDR_W];
    word_t instr;

    // Program load port, only open while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst && imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    assign instr = imem[pc[IMEM_ADDR_W+1:2]];  // Word address, wraps

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (branch_taken_i) begin
            pc <= branch_target_i;
        end else if (!stall_i) begin
            pc <= pc + 32'd4;
        end
    end

    ////////////////////
    // IF/ID register
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_instr_o <= NOP_INSTR;
            if_id_pc_o    <= '0;
        end else if (flush_i) begin
            if_id_instr_o <= NOP_INSTR;  // Squash the wrong-path fetch
        end else if (!stall_i) begin
            if_id_instr_o <= instr;
            if_id_pc_o    <= pc;
        end
    end

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall_i,
    input  logic              flush_i,
    input  rv_pkg::word_t     if_id_instr_i,
    input  rv_pkg::word_t     if_id_pc_i,
    input  logic              wb_we_i,
    input  rv_pkg::reg_addr_t wb_rd_i,
    input  rv_pkg::word_t     wb_data_i,
    output rv_pkg::reg_addr_t rs1_addr_o,
    output rv_pkg::reg_addr_t rs2_addr_o,
    output rv_pkg::reg_addr_t id_ex_rs1_addr_o,
    output rv_pkg::reg_addr_t id_ex_rs2_addr_o,
    output rv_pkg::reg_addr_t id_ex_rd_o,
    output rv_pkg::word_t     id_ex_rs1_data_o,
    output rv_pkg::word_t     id_ex_rs2_data_o,
    output rv_pkg::word_t     id_ex_imm_o,
    output rv_pkg::word_t     id_ex_pc_o,
    output rv_pkg::alu_op_e   id_ex_alu_op_o,
    output logic              id_ex_use_imm_o,
    output logic              id_ex_mem_read_o,
    output logic              id_ex_mem_write_o,
    output logic              id_ex_reg_write_o,
    output logic              id_ex_branch_o,
    output logic              id_ex_branch_ne_o
);
    import rv_pkg::*;

    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    word_t      imm, rs1_data, rs2_data;
    word_t      regs [32];
    alu_op_e    alu_op;
    logic       use_imm, mem_read, mem_write, reg_write, branch;

    assign opcode = if_id_instr_i[6:0];
    assign funct3 = if_id_instr_i[14:12];
    assign funct7 = if_id_instr_i[31:25];
    assign rs1_addr_o = if_id_instr_i[19:15];
    // rs2 field is immediate bits for I-type, keep it out of the hazard check
    assign rs2_addr_o = (opcode == OPC_ITYPE || opcode == OPC_LOAD) ? '0 : if_id_instr_i[24:20];

    ////////////////////
    // Decoder and immediate
    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        imm       = {{20{if_id_instr_i[31]}}, if_id_instr_i[31:20]};  // I form
        case (opcode)
            OPC_RTYPE: begin
                reg_write = 1'b1;
                case (funct3)
                    F3_ADD: alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_XOR: alu_op = ALU_XOR;
                    F3_OR:  alu_op = ALU_OR;
                    F3_AND: alu_op = ALU_AND;
                    F3_SLT: alu_op = ALU_SLT;
                    default: reg_write = 1'b0;  // Shifts dropped
                endcase
            end
            OPC_ITYPE: begin
                use_imm   = 1'b1;
                reg_write = (funct3 == F3_ADD);  // ADDI only
            end
            OPC_LOAD: begin
                use_imm   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OPC_STORE: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
                imm       = {{20{if_id_instr_i[31]}}, if_id_instr_i[31:25],
                             if_id_instr_i[11:7]};
            end
            OPC_BRANCH: begin
                branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                imm    = {{19{if_id_instr_i[31]}}, if_id_instr_i[31], if_id_instr_i[7],
                          if_id_instr_i[30:25], if_id_instr_i[11:8], 1'b0};
            end
            default: ;  // Anything else is a no-op
        endcase
    end

    ////////////////////
    // Register file, write-through to the read ports
    always_ff @(posedge clk) begin
        if (wb_we_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    assign rs1_data = (rs1_addr_o == '0) ? '0 :
                      (wb_we_i && wb_rd_i == rs1_addr_o) ? wb_data_i : regs[rs1_addr_o];
    assign rs2_data = (rs2_addr_o == '0) ? '0 :
                      (wb_we_i && wb_rd_i == rs2_addr_o) ? wb_data_i : regs[rs2_addr_o];

    ////////////////////
    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst || stall_i || flush_i) begin
            id_ex_alu_op_o    <= ALU_ADD;  // Bubble
            id_ex_use_imm_o   <= 1'b0;
            id_ex_mem_read_o  <= 1'b0;
            id_ex_mem_write_o <= 1'b0;
            id_ex_reg_write_o <= 1'b0;
            id_ex_branch_o    <= 1'b0;
            id_ex_branch_ne_o <= 1'b0;
        end else begin
            id_ex_alu_op_o    <= alu_op;
            id_ex_use_imm_o   <= use_imm;
            id_ex_mem_read_o  <= mem_read;
            id_ex_mem_write_o <= mem_write;
            id_ex_reg_write_o <= reg_write;
            id_ex_branch_o    <= branch;
            id_ex_branch_ne_o <= (funct3 == F3_BNE);
        end
    end

    always_ff @(posedge clk) begin
        id_ex_rs1_addr_o <= rs1_addr_o;
        id_ex_rs2_addr_o <= rs2_addr_o;
        id_ex_rd_o       <= if_id_instr_i[11:7];
        id_ex_rs1_data_o <= rs1_data;
        id_ex_rs2_data_o <= rs2_data;
        id_ex_imm_o      <= imm;
        id_ex_pc_o       <= if_id_pc_i;
    end

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::word_t     id_ex_rs1_data_i,
    input  rv_pkg::word_t     id_ex_rs2_data_i,
    input  rv_pkg::word_t     id_ex_imm_i,
    input  rv_pkg::word_t     id_ex_pc_i,
    input  rv_pkg::reg_addr_t id_ex_rd_i,
    input  rv_pkg::alu_op_e   id_ex_alu_op_i,
    input  logic              id_ex_use_imm_i,
    input  logic              id_ex_mem_read_i,
    input  logic              id_ex_mem_write_i,
    input  logic              id_ex_reg_write_i,
    input  logic              id_ex_branch_i,
    input  logic              id_ex_branch_ne_i,
    input  rv_pkg::fwd_sel_e  fwd_a_i,
    input  rv_pkg::fwd_sel_e  fwd_b_i,
    input  rv_pkg::word_t     wb_data_i,
    output logic              branch_taken_o,
    output rv_pkg::word_t     branch_target_o,
    output rv_pkg::word_t     ex_mem_alu_o,
    output rv_pkg::word_t     ex_mem_store_data_o,
    output rv_pkg::reg_addr_t ex_mem_rd_o,
    output logic              ex_mem_mem_read_o,
    output logic              ex_mem_mem_write_o,
    output logic              ex_mem_reg_write_o
);
    import rv_pkg::*;

    word_t op_a, op_b_reg, op_b, alu_result;
    logic  equal;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a     = fwd_mux(fwd_a_i, id_ex_rs1_data_i, ex_mem_alu_o, wb_data_i);
    assign op_b_reg = fwd_mux(fwd_b_i, id_ex_rs2_data_i, ex_mem_alu_o, wb_data_i);
    assign op_b     = id_ex_use_imm_i ? id_ex_imm_i : op_b_reg;

    ////////////////////
    // ALU
    always_comb begin
        case (id_ex_alu_op_i)
            ALU_SUB: alu_result = op_a - op_b;  // Wraps
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b;
        endcase
    end

    // Branch resolves here, compares forwarded registers
    assign equal           = (op_a == op_b_reg);
    assign branch_taken_o  = id_ex_branch_i && (id_ex_branch_ne_i ? !equal : equal);
    assign branch_target_o = id_ex_pc_i + id_ex_imm_i;

    ////////////////////
    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_mem_read_o  <= 1'b0;
            ex_mem_mem_write_o <= 1'b0;
            ex_mem_reg_write_o <= 1'b0;
        end else begin
            ex_mem_mem_read_o  <= id_ex_mem_read_i;
            ex_mem_mem_write_o <= id_ex_mem_write_i;
            ex_mem_reg_write_o <= id_ex_reg_write_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_alu_o        <= alu_result;
        ex_mem_store_data_o <= op_b_reg;  // Forwarded rs2
        ex_mem_rd_o         <= id_ex_rd_i;
    end

endmodule

/* rtl/memory_stage.sv */
module memory_stage (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::word_t      ex_mem_alu_i,
    input  rv_pkg::word_t      ex_mem_store_data_i,
    input  rv_pkg::reg_addr_t  ex_mem_rd_i,
    input  logic               ex_mem_mem_read_i,
    input  logic               ex_mem_mem_write_i,
    input  logic               ex_mem_reg_write_i,
    output logic               dm_we_o,
    output rv_pkg::dmem_addr_t dm_addr_o,
    output rv_pkg::word_t      dm_wdata_o,
    output logic               wb_we_o,
    output rv_pkg::reg_addr_t  wb_rd_o,
    output rv_pkg::word_t      wb_data_o
);
    import rv_pkg::*;

    word_t dmem [2**DMEM_ADDR_W];
    word_t mem_wb_load_data, mem_wb_alu;
    logic  mem_wb_load;

    // Store monitor shows the write in the cycle it happens
    assign dm_we_o    = ex_mem_mem_write_i;
    assign dm_addr_o  = ex_mem_alu_i[DMEM_ADDR_W+1:2];  // Word address, wraps
    assign dm_wdata_o = ex_mem_store_data_i;

    always_ff @(posedge clk) begin
        if (dm_we_o) begin
            dmem[dm_addr_o] <= dm_wdata_o;
        end
    end

    ////////////////////
    // MEM/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb_load <= 1'b0;
            wb_we_o     <= 1'b0;
        end else begin
            mem_wb_load <= ex_mem_mem_read_i;
            wb_we_o     <= ex_mem_reg_write_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_load_data <= dmem[dm_addr_o];
        mem_wb_alu       <= ex_mem_alu_i;
        wb_rd_o          <= ex_mem_rd_i;
    end

    assign wb_data_o = mem_wb_load ? mem_wb_load_data : mem_wb_alu;

endmodule

/* rtl/rv_core_top.sv */
module rv_core_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               imem_we_i,
    input  rv_pkg::imem_addr_t imem_addr_i,
    input  rv_pkg::word_t      imem_wdata_i,
    output logic               dm_we_o,
    output rv_pkg::dmem_addr_t dm_addr_o,
    output rv_pkg::word_t      dm_wdata_o
);
    import rv_pkg::*;

    // Hazard unit
    logic      stall, flush;
    fwd_sel_e  fwd_a, fwd_b;

    // IF/ID
    word_t     if_id_instr, if_id_pc;

    // Decode sources and ID/EX
    reg_addr_t rs1_addr, rs2_addr;
    reg_addr_t id_ex_rs1_addr, id_ex_rs2_addr, id_ex_rd;
    word_t     id_ex_rs1_data, id_ex_rs2_data, id_ex_imm, id_ex_pc;
    alu_op_e   id_ex_alu_op;
    logic      id_ex_use_imm, id_ex_mem_read, id_ex_mem_write, id_ex_reg_write;
    logic      id_ex_branch, id_ex_branch_ne;

    // Branch back to fetch and EX/MEM
    logic      branch_taken;
    word_t     branch_target;
    word_t     ex_mem_alu, ex_mem_store_data;
    reg_addr_t ex_mem_rd;
    logic      ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write;

    // Writeback
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst             (rst),
        .imem_we_i       (imem_we_i),
        .imem_addr_i     (imem_addr_i),
        .imem_wdata_i    (imem_wdata_i),
        .stall_i         (stall),
        .flush_i         (flush),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .if_id_instr_o   (if_id_instr),
        .if_id_pc_o      (if_id_pc)
    );

    decode_stage u_decode (
        .clk               (clk),
        .rst               (rst),
        .stall_i           (stall),
        .flush_i           (flush),
        .if_id_instr_i     (if_id_instr),
        .if_id_pc_i        (if_id_pc),
        .wb_we_i           (wb_we),
        .wb_rd_i           (wb_rd),
        .wb_data_i         (wb_data),
        .rs1_addr_o        (rs1_addr),
        .rs2_addr_o        (rs2_addr),
        .id_ex_rs1_addr_o  (id_ex_rs1_addr),
        .id_ex_rs2_addr_o  (id_ex_rs2_addr),
        .id_ex_rd_o        (id_ex_rd),
        .id_ex_rs1_data_o  (id_ex_rs1_data),
        .id_ex_rs2_data_o  (id_ex_rs2_data),
        .id_ex_imm_o       (id_ex_imm),
        .id_ex_pc_o        (id_ex_pc),
        .id_ex_alu_op_o    (id_ex_alu_op),
        .id_ex_use_imm_o   (id_ex_use_imm),
        .id_ex_mem_read_o  (id_ex_mem_read),
        .id_ex_mem_write_o (id_ex_mem_write),
        .id_ex_reg_write_o (id_ex_reg_write),
        .id_ex_branch_o    (id_ex_branch),
        .id_ex_branch_ne_o (id_ex_branch_ne)
    );

    execute_stage u_execute (
        .clk                 (clk),
        .rst                 (rst),
        .id_ex_rs1_data_i    (id_ex_rs1_data),
        .id_ex_rs2_data_i    (id_ex_rs2_data),
        .id_ex_imm_i         (id_ex_imm),
        .id_ex_pc_i          (id_ex_pc),
        .id_ex_rd_i          (id_ex_rd),
        .id_ex_alu_op_i      (id_ex_alu_op),
        .id_ex_use_imm_i     (id_ex_use_imm),
        .id_ex_mem_read_i    (id_ex_mem_read),
        .id_ex_mem_write_i   (id_ex_mem_write),
        .id_ex_reg_write_i   (id_ex_reg_write),
        .id_ex_branch_i      (id_ex_branch),
        .id_ex_branch_ne_i   (id_ex_branch_ne),
        .fwd_a_i             (fwd_a),
        .fwd_b_i             (fwd_b),
        .wb_data_i           (wb_data),
        .branch_taken_o      (branch_taken),
        .branch_target_o     (branch_target),
        .ex_mem_alu_o        (ex_mem_alu),
        .ex_mem_store_data_o (ex_mem_store_data),
        .ex_mem_rd_o         (ex_mem_rd),
        .ex_mem_mem_read_o   (ex_mem_mem_read),
        .ex_mem_mem_write_o  (ex_mem_mem_write),
        .ex_mem_reg_write_o  (ex_mem_reg_write)
    );

    memory_stage u_memory (
        .clk                 (clk),
        .rst                 (rst),
        .ex_mem_alu_i        (ex_mem_alu),
        .ex_mem_store_data_i (ex_mem_store_data),
        .ex_mem_rd_i         (ex_mem_rd),
        .ex_mem_mem_read_i   (ex_mem_mem_read),
        .ex_mem_mem_write_i  (ex_mem_mem_write),
        .ex_mem_reg_write_i  (ex_mem_reg_write),
        .dm_we_o             (dm_we_o),
        .dm_addr_o           (dm_addr_o),
        .dm_wdata_o          (dm_wdata_o),
        .wb_we_o             (wb_we),
        .wb_rd_o             (wb_rd),
        .wb_data_o           (wb_data)
    );

    hazard_unit u_hazard (
        .rs1_addr_i         (rs1_addr),
        .rs2_addr_i         (rs2_addr),
        .id_ex_rd_i         (id_ex_rd),
        .id_ex_mem_read_i   (id_ex_mem_read),
        .id_ex_rs1_addr_i   (id_ex_rs1_addr),
        .id_ex_rs2_addr_i   (id_ex_rs2_addr),
        .ex_mem_rd_i        (ex_mem_rd),
        .ex_mem_reg_write_i (ex_mem_reg_write),
        .mem_wb_rd_i        (wb_rd),
        .mem_wb_reg_write_i (wb_we),
        .branch_taken_i     (branch_taken),
        .stall_o            (stall),
        .flush_o            (flush),
        .fwd_a_o            (fwd_a),
        .fwd_b_o            (fwd_b)
    );

endmodule

/* test/rv_core_asserts.sv */
module rv_core_asserts (
    input logic clk,
    input logic rst,
    input logic stall_i,
    input logic id_ex_mem_read_i,
    input logic dm_we_i
);
    int   failures;
    logic reset_seen = 1'b0;  // Set once the EX/MEM reset has taken effect

    always @(posedge clk) begin
        if (rst) begin
            reset_seen <= 1'b1;
        end
    end

    // A stall only ever covers a load in EX
    stall_on_load: assert property (@(posedge clk) disable iff (rst) stall_i |-> id_ex_mem_read_i)
        else begin
            $error("stall raised without a load in EX");
            failures++;
        end

    quiet_in_reset: assert property (@(posedge clk) (rst && reset_seen) |-> !dm_we_i)
        else begin
            $error("store strobe high while rst is high");
            failures++;
        end

    we_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(dm_we_i))
        else begin
            $error("store strobe unknown after reset");
            failures++;
        end

endmodule

bind rv_core_top rv_core_asserts u_asserts (
    .clk              (clk),
    .rst              (rst),
    .stall_i          (stall),
    .id_ex_mem_read_i (id_ex_mem_read),
    .dm_we_i          (dm_we_o)
);

/* test/rv_core_checker.sv */
module rv_core_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               dm_we_i,
    input  rv_pkg::dmem_addr_t dm_addr_i,
    input  rv_pkg::word_t      dm_wdata_i,
    output int                 store_count_o,
    output int                 failed_tests_o
);
    import rv_pkg::*;

    string      test_name = "none";
    int         exp_count;
    dmem_addr_t exp_addr [4];
    word_t      exp_data [4];
    int         error_total;
    int         errors_at_start;
    int         passed_tests;

    task automatic start_test(input string name, input int count);
        test_name       = name;
        exp_count       = count;
        errors_at_start = error_total;
    endtask

    task automatic expect_store(input int idx, input dmem_addr_t addr, input word_t data);
        exp_addr[idx] = addr;
        exp_data[idx] = data;
    endtask

    task automatic end_test(input bit timed_out);
        int errs;
        errs = error_total - errors_at_start;
        if (timed_out || errs != 0) begin
            failed_tests_o++;
            $display("FAIL %s: %0d of %0d stores, %0d errors", test_name, store_count_o,
                     exp_count, errs);
        end else begin
            passed_tests++;
            $display("PASS %s: %0d stores", test_name, store_count_o);
        end
    endtask

    task automatic report_totals();
        $display("Totals: %0d tests, %0d passed, %0d failed",
                 passed_tests + failed_tests_o, passed_tests, failed_tests_o);
    endtask

    ////////////////////
    // Store monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            if (dm_we_i === 1'b1) begin
                $display("Store seen during reset in test %s, address %0d", test_name,
                         dm_addr_i);
                error_total++;
            end
            store_count_o = 0;
        end else if (dm_we_i === 1'b1) begin
            if (store_count_o >= exp_count) begin
                $display("Unexpected store in test %s: address %0d, data 0x%08h", test_name,
                         dm_addr_i, dm_wdata_i);
                error_total++;
            end else begin
                if (dm_addr_i !== exp_addr[store_count_o]) begin
                    $display("ERROR %s store %0d address: expected %0d, actual %0d", test_name,
                             store_count_o, exp_addr[store_count_o], dm_addr_i);
                    error_total++;
                end
                if (dm_wdata_i !== exp_data[store_count_o]) begin
                    $display("ERROR %s store %0d data: expected 0x%08h, actual 0x%08h",
                             test_name, store_count_o, exp_data[store_count_o], dm_wdata_i);
                    error_total++;
                end
            end
            store_count_o++;
        end
    end

endmodule

/* test/tb_rv_core.sv */
module tb_rv_core;
    import rv_pkg::*;

    localparam int    N_TESTS   = 7;
    localparam int    MAX_WORDS = 14;
    localparam int    MAX_WAIT  = 300;
    localparam int    QUIET     = 20;             // Cycles watched after the last store
    localparam word_t LOOP      = 32'h0000_0063;  // BEQ x0, x0, 0

    logic       clk = 1'b0;
    logic       rst;
    logic       imem_we;
    imem_addr_t imem_addr;
    word_t      imem_wdata;
    logic       dm_we;
    dmem_addr_t dm_addr;
    word_t      dm_wdata;
    int         store_count;
    int         failed_tests;

    string      names [N_TESTS];
    word_t      prog [N_TESTS][MAX_WORDS];
    int         store_total [N_TESTS];
    dmem_addr_t exp_addr [N_TESTS][4];
    word_t      exp_data [N_TESTS][4];

    always #20 clk = ~clk;

    rv_core_top DUT (
        .clk          (clk),
        .rst          (rst),
        .imem_we_i    (imem_we),
        .imem_addr_i  (imem_addr),
        .imem_wdata_i (imem_wdata),
        .dm_we_o      (dm_we),
        .dm_addr_o    (dm_addr),
        .dm_wdata_o   (dm_wdata)
    );

    rv_core_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .dm_we_i        (dm_we),
        .dm_addr_i      (dm_addr),
        .dm_wdata_i     (dm_wdata),
        .store_count_o  (store_count),
        .failed_tests_o (failed_tests)
    );

    ////////////////////
    // Program table
    task automatic fill_table();
        // ADDI, ADD, SUB, AND, ADDI chain, each result stored at once
        names[0]       = "alu_add_sub_and";
        prog[0]        = '{32'h06400093, 32'h00700113, 32'h002081B3, 32'h00302023,
                           32'h40310233, 32'h00402223, 32'h001272B3, 32'h00502423,
                           32'hFFB28313, 32'h00602623, LOOP, NOP_INSTR, NOP_INSTR, NOP_INSTR};
        store_total[0] = 4;
        exp_addr[0]    = '{6'd0, 6'd1, 6'd2, 6'd3};
        exp_data[0]    = '{32'd100 + 32'd7, 32'd7 - 32'd107, 32'hFFFFFF9C & 32'd100,
                           32'd4 - 32'd5};
        // OR, XOR, SLT chain on a negative value
        names[1]       = "alu_or_xor_slt";
        prog[1]        = '{32'hFF800093, 32'h00300113, 32'h0020E1B3, 32'h00302823,
                           32'h0021C233, 32'h00402A23, 32'h002222B3, 32'h00502C23,
                           32'h00512333, 32'h00602E23, LOOP, NOP_INSTR, NOP_INSTR, NOP_INSTR};
        store_total[1] = 4;
        exp_addr[1]    = '{6'd4, 6'd5, 6'd6, 6'd7};
        exp_data[1]    = '{32'hFFFFFFF8 | 32'd3, 32'hFFFFFFFB ^ 32'd3, 32'd1, 32'd0};  // -8 < 3
        // SW, LW, dependent ADD, SW
        names[2]       = "load_use_stall";
        prog[2]        = '{32'h02A00093, 32'h3E800113, 32'h02102023, 32'h02002183,
                           32'h00218233, 32'h02402223, LOOP, NOP_INSTR,
                           NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR};
        store_total[2] = 2;
        exp_addr[2]    = '{6'd8, 6'd9, 6'd0, 6'd0};
        exp_data[2]    = '{32'd42, 32'd42 + 32'd1000, 32'd0, 32'd0};
        // BEQ over two stores to a third
        names[3]       = "beq_taken";
        prog[3]        = '{32'h00900093, 32'h00900113, 32'h00208663, 32'h02102423,
                           32'h02202623, 32'h02102823, LOOP, NOP_INSTR,
                           NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR};
        store_total[3] = 1;
        exp_addr[3]    = '{6'd12, 6'd0, 6'd0, 6'd0};
        exp_data[3]    = '{32'd9, 32'd0, 32'd0, 32'd0};
        names[4]       = "bne_not_taken";
        prog[4]        = '{32'h00500093, 32'h00500113, 32'h00209663, 32'h02102A23,
                           32'h00108193, 32'h02302C23, LOOP, NOP_INSTR,
                           NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR};
        store_total[4] = 2;
        exp_addr[4]    = '{6'd13, 6'd14, 6'd0, 6'd0};
        exp_data[4]    = '{32'd5, 32'd5 + 32'd1, 32'd0, 32'd0};
        // Write to x0, then stores at 252, 256 and -4
        names[5]       = "x0_and_wrap";
        prog[5]        = '{32'h04D00013, 32'hFFC00093, 32'h0E002E23, 32'h07B00113,
                           32'h10202023, 32'h0020A023, LOOP, NOP_INSTR,
                           NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR};
        store_total[5] = 3;
        exp_addr[5]    = '{6'd63, 6'd0, 6'd63, 6'd0};
        exp_data[5]    = '{32'd0, 32'd123, 32'd123, 32'd0};
        names[6]       = "reset_quiet";  // No SW at all
        prog[6]        = '{32'h00100093, 32'h00108133, LOOP, NOP_INSTR, NOP_INSTR, NOP_INSTR,
                           NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR, NOP_INSTR,
                           NOP_INSTR, NOP_INSTR};
        store_total[6] = 0;
        exp_addr[6]    = '{6'd0, 6'd0, 6'd0, 6'd0};
        exp_data[6]    = '{32'd0, 32'd0, 32'd0, 32'd0};
    endtask

    // Reset held for 16 cycles, one instruction word written per cycle
    task automatic load_program(input int t);
        int i;
        for (i = 0; i < 2**IMEM_ADDR_W; i++) begin
            @(posedge clk);
            rst        <= 1'b1;
            imem_we    <= 1'b1;
            imem_addr  <= imem_addr_t'(i);
            imem_wdata <= (i < MAX_WORDS) ? prog[t][i] : NOP_INSTR;
        end
        @(posedge clk);
        imem_we <= 1'b0;
        rst     <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int i;
        int cycles;
        bit timed_out;
        u_checker.start_test(names[t], store_total[t]);
        for (i = 0; i < 4; i++) begin
            u_checker.expect_store(i, exp_addr[t][i], exp_data[t][i]);
        end
        load_program(t);
        cycles = 0;
        while (store_count < store_total[t] && cycles < MAX_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        timed_out = (store_count < store_total[t]);
        if (timed_out) begin
            $display("Test %s produced too few stores within %0d cycles (%0d of %0d)",
                     names[t], MAX_WAIT, store_count, store_total[t]);
        end
        cycles = 0;
        while (cycles < QUIET) begin  // Late or extra stores still reach the checker
            @(posedge clk);
            cycles++;
        end
        u_checker.end_test(timed_out);
    endtask

    initial begin
        rst        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        fill_table();
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        u_checker.report_totals();
        if (failed_tests == 0 && DUT.u_asserts.failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* rv_core_top.f */
rtl/rv_pkg.sv
rtl/hazard_unit.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/rv_core_top.sv
test/rv_core_asserts.sv
test/rv_core_checker.sv
test/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv_core
FILELIST  := rv_core_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
